// ==== src/ds_settings.svh ====
// Downstream unpacker protocol constants and counter widths
`ifndef DS_SETTINGS_SVH
`define DS_SETTINGS_SVH

// UDP port carrying the protocol
`define DS_PORT 16'd1024

`define DS_PRE0 8'hef
`define DS_PRE1 8'hfe

// Packet type bytes
`define DS_TYPE_DATA 8'h01
`define DS_TYPE_DISC 8'h02
`define DS_TYPE_RUN 8'h04

`define DS_ENDPOINT_TX 8'h02
`define DS_SYNC 8'h7f

// Sample groups per subframe
`define DS_SAMPLES 63
`define DS_WD_BITS 10

`endif

// ==== src/ds_pkg.sv ====
// Downstream unpacker shared types for byte beats, commands and sample words
package ds_pkg;

  // One payload byte tagged with its role in the frame
  typedef struct packed {
    logic [7:0] data;
    logic       lr_valid;
    logic       iq_valid;
    // Final byte of a four-byte sample group
    logic       last;
  } ds_beat_t;

  // Radio command taken from the control byte and four data bytes
  typedef struct packed {
    logic        resprqst;
    logic [5:0]  addr;
    logic        ptt;
    logic [31:0] data;
  } ds_cmd_t;

  // Left/right or I/Q pair
  typedef struct packed {
    logic [15:0] first;
    logic [15:0] second;
  } ds_sample_t;

endpackage

// ==== src/ds_frame_parser.sv ====
// Downstream frame parser that decodes packet types and tags each payload byte
`timescale 1ns/1ps
`include "ds_settings.svh"

module ds_frame_parser (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        eth_port,
  input  logic               eth_broadcast,
  input  logic               eth_valid,
  input  logic [7:0]         eth_data,
  input  logic               eth_unreachable,
  input  logic               expired,
  output logic               run,
  output logic               wide_spectrum,
  output logic               discovery,
  output logic               frame_seen,
  output ds_pkg::ds_beat_t   beat,
  output logic               cmd_valid,
  output ds_pkg::ds_cmd_t    cmd
);

  localparam logic [5:0] LAST_GROUP = 6'(`DS_SAMPLES - 1);

  typedef enum logic [3:0] {
    S_PRE0,
    S_PRE1,
    S_TYPE,
    S_RUNSTOP,
    S_DISC,
    S_ENDPOINT,
    S_SEQ,
    S_SYNC,
    S_CTRL,
    S_DATA,
    S_GROUP
  } state_t;

  state_t     state;
  // Byte index inside the current field or sample group
  logic [2:0] idx;
  logic [5:0] group;
  logic       subframe;

  always_ff @(posedge clk) begin
    cmd_valid <= 1'b0;
    if (reset) begin
      state         <= S_PRE0;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
      idx           <= 3'd0;
      group         <= 6'd0;
      subframe      <= 1'b0;
    end else if (eth_unreachable || expired) begin
      state         <= S_PRE0;
      run           <= 1'b0;
      wide_spectrum <= 1'b0;
    end else if (!eth_valid) begin
      state <= S_PRE0;
    end else begin
      case (state)
        S_PRE0: begin
          if (eth_data == `DS_PRE0 && eth_port == `DS_PORT) state <= S_PRE1;
        end
        S_PRE1: begin
          state <= (eth_data == `DS_PRE1 && eth_port == `DS_PORT) ? S_TYPE : S_PRE0;
        end
        S_TYPE: begin
          if (eth_data == `DS_TYPE_DATA) state <= S_ENDPOINT;
          else if (eth_data == `DS_TYPE_RUN) state <= S_RUNSTOP;
          else if (eth_data == `DS_TYPE_DISC && eth_broadcast) state <= S_DISC;
          else state <= S_PRE0;
        end
        S_RUNSTOP: begin
          run           <= eth_data[0];
          wide_spectrum <= eth_data[1];
          state         <= S_PRE0;
        end
        S_ENDPOINT: begin
          idx      <= 3'd0;
          subframe <= 1'b0;
          state    <= (eth_data == `DS_ENDPOINT_TX) ? S_SEQ : S_PRE0;
        end
        // Sequence number is not checked
        S_SEQ: begin
          idx <= (idx == 3'd3) ? 3'd0 : idx + 3'd1;
          if (idx == 3'd3) state <= S_SYNC;
        end
        S_SYNC: begin
          idx <= (idx == 3'd2) ? 3'd0 : idx + 3'd1;
          if (eth_data != `DS_SYNC) state <= S_PRE0;
          else if (idx == 3'd2) state <= S_CTRL;
        end
        S_CTRL: begin
          idx   <= 3'd0;
          state <= S_DATA;
        end
        S_DATA: begin
          idx <= (idx == 3'd3) ? 3'd0 : idx + 3'd1;
          if (idx == 3'd3) begin
            cmd_valid <= 1'b1;
            group     <= 6'd0;
            state     <= S_GROUP;
          end
        end
        // Four L/R bytes then four I/Q bytes per group
        S_GROUP: begin
          idx <= idx + 3'd1;
          if (idx == 3'd7) begin
            if (group != LAST_GROUP) begin
              group <= group + 6'd1;
            end else if (!subframe) begin
              subframe <= 1'b1;
              state    <= S_SYNC;
            end else begin
              state <= S_PRE0;
            end
          end
        end
        default: state <= S_PRE0;
      endcase
    end
  end

  // Command fields with data bytes arriving big-endian
  always_ff @(posedge clk) begin
    if (eth_valid && state == S_CTRL) begin
      cmd.resprqst <= eth_data[7];
      cmd.addr     <= eth_data[6:1];
      cmd.ptt      <= eth_data[0];
    end else if (eth_valid && state == S_DATA) begin
      cmd.data <= {cmd.data[23:0], eth_data};
    end
  end

  assign discovery  = (state == S_DISC);
  assign frame_seen = eth_valid && state == S_SEQ && idx == 3'd3;

  always_comb begin
    beat.data     = eth_data;
    beat.lr_valid = eth_valid && state == S_GROUP && !idx[2];
    beat.iq_valid = eth_valid && state == S_GROUP && idx[2];
    beat.last     = eth_valid && state == S_GROUP && idx[1:0] == 2'b11;
  end

  assert property (@(posedge clk) disable iff (reset)
                   state == S_GROUP |-> group <= LAST_GROUP);

endmodule

// ==== src/ds_watchdog.sv ====
// Watchdog counting transmit ticks while running without incoming data frames
`timescale 1ns/1ps
`include "ds_settings.svh"

module ds_watchdog (
  input  logic clk,
  input  logic reset,
  input  logic run,
  input  logic frame_seen,
  input  logic watchdog_up,
  output logic expired
);

  logic [`DS_WD_BITS-1:0] count;

  // Held at zero while stopped, saturates once expired
  always_ff @(posedge clk) begin
    if (reset || !run || frame_seen) begin
      count <= '0;
    end else if (watchdog_up && !expired) begin
      count <= count + 1'b1;
    end
  end

  assign expired = &count;

endmodule

// ==== src/ds_cmd_queue.sv ====
// Two-entry command queue with four-phase req/ack delivery and overrun flag
`timescale 1ns/1ps

module ds_cmd_queue (
  input  logic            clk,
  input  logic            reset,
  input  logic            cmd_valid,
  input  ds_pkg::ds_cmd_t cmd_in,
  input  logic            cmd_ack,
  output logic            cmd_req,
  output ds_pkg::ds_cmd_t cmd,
  output logic            cmd_overrun
);

  typedef enum logic [1:0] {
    Q_IDLE,
    Q_REQ,
    Q_DROP
  } phase_t;

  phase_t          phase;
  ds_pkg::ds_cmd_t wait_cmd;
  logic            wait_full;
  logic            load_in;
  logic            load_wait;
  logic            store_wait;

  // Presenting slot frees once ack has fallen
  assign load_wait  = phase == Q_DROP && !cmd_ack && wait_full;
  assign load_in    = cmd_valid &&
                      (phase == Q_IDLE || (phase == Q_DROP && !cmd_ack && !wait_full));
  assign store_wait = cmd_valid && !load_in;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase       <= Q_IDLE;
      wait_full   <= 1'b0;
      cmd_overrun <= 1'b0;
    end else begin
      if (load_in || load_wait) phase <= Q_REQ;
      else if (phase == Q_REQ && cmd_ack) phase <= Q_DROP;
      else if (phase == Q_DROP && !cmd_ack) phase <= Q_IDLE;

      if (store_wait) begin
        wait_full <= 1'b1;
        // Waiting command lost
        if (wait_full && !load_wait) cmd_overrun <= 1'b1;
      end else if (load_wait) begin
        wait_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_in) cmd <= cmd_in;
    else if (load_wait) cmd <= wait_cmd;
    if (store_wait) wait_cmd <= cmd_in;
  end

  assign cmd_req = (phase == Q_REQ);

  assert property (@(posedge clk) disable iff (reset) cmd_req |=> !cmd_req || $stable(cmd));
  assert property (@(posedge clk) disable iff (reset) $rose(cmd_req) |-> !cmd_ack);

endmodule

// ==== src/ds_sample_packer.sv ====
// Sample packer that builds 32-bit L/R and I/Q words from tagged bytes
`timescale 1ns/1ps
`include "ds_settings.svh"

module ds_sample_packer (
  input  logic               clk,
  input  logic               reset,
  input  ds_pkg::ds_beat_t   beat,
  output logic               lr_valid,
  output logic               iq_valid,
  output logic               subframe_last,
  output ds_pkg::ds_sample_t sample
);

  localparam logic [5:0] LAST_GROUP = 6'(`DS_SAMPLES - 1);

  logic [23:0] shift;
  logic [5:0]  group;

  // First byte of a group ends up most significant
  always_ff @(posedge clk) begin
    if (beat.lr_valid || beat.iq_valid) shift <= {shift[15:0], beat.data};
    if (beat.last) sample <= {shift, beat.data};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lr_valid      <= 1'b0;
      iq_valid      <= 1'b0;
      subframe_last <= 1'b0;
      group         <= 6'd0;
    end else begin
      lr_valid      <= beat.last && beat.lr_valid;
      iq_valid      <= beat.last && beat.iq_valid;
      subframe_last <= beat.last && group == LAST_GROUP;
      // Groups run back to back within a subframe, so any gap restarts the count
      if (!beat.lr_valid && !beat.iq_valid) begin
        group <= 6'd0;
      end else if (beat.last && beat.iq_valid) begin
        group <= (group == LAST_GROUP) ? 6'd0 : group + 6'd1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) beat.last |-> beat.lr_valid || beat.iq_valid);

endmodule

// ==== src/ds_unpacker_top.sv ====
// Downstream unpacker top joining parser, watchdog, command queue and packer
`timescale 1ns/1ps

module ds_unpacker_top (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        eth_port,
  input  logic               eth_broadcast,
  input  logic               eth_valid,
  input  logic [7:0]         eth_data,
  input  logic               eth_unreachable,
  input  logic               watchdog_up,
  input  logic               cmd_ack,
  output logic               run,
  output logic               wide_spectrum,
  output logic               discovery,
  output logic               cmd_req,
  output ds_pkg::ds_cmd_t    cmd,
  output logic               cmd_overrun,
  output logic               lr_valid,
  output logic               iq_valid,
  output logic               subframe_last,
  output ds_pkg::ds_sample_t sample
);

  ds_pkg::ds_beat_t beat;
  ds_pkg::ds_cmd_t  parsed_cmd;
  logic             parsed_valid;
  logic             frame_seen;
  logic             expired;

  ds_frame_parser u_parser (
    .clk             (clk),
    .reset           (reset),
    .eth_port        (eth_port),
    .eth_broadcast   (eth_broadcast),
    .eth_valid       (eth_valid),
    .eth_data        (eth_data),
    .eth_unreachable (eth_unreachable),
    .expired         (expired),
    .run             (run),
    .wide_spectrum   (wide_spectrum),
    .discovery       (discovery),
    .frame_seen      (frame_seen),
    .beat            (beat),
    .cmd_valid       (parsed_valid),
    .cmd             (parsed_cmd)
  );

  ds_watchdog u_watchdog (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .frame_seen  (frame_seen),
    .watchdog_up (watchdog_up),
    .expired     (expired)
  );

  ds_cmd_queue u_cmd_queue (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (parsed_valid),
    .cmd_in      (parsed_cmd),
    .cmd_ack     (cmd_ack),
    .cmd_req     (cmd_req),
    .cmd         (cmd),
    .cmd_overrun (cmd_overrun)
  );

  ds_sample_packer u_packer (
    .clk           (clk),
    .reset         (reset),
    .beat          (beat),
    .lr_valid      (lr_valid),
    .iq_valid      (iq_valid),
    .subframe_last (subframe_last),
    .sample        (sample)
  );

endmodule

// ==== testbench/tb_ds_unpacker.sv ====
// Testbench for the downstream unpacker with frame builder, reference model and checker
`timescale 1ns/1ps
`include "ds_settings.svh"

module tb_ds_unpacker;

  localparam int FRAME_LEN = 8 + 2 * (8 + 8 * `DS_SAMPLES);
  localparam int FAST_ACK  = 2;
  localparam int SLOW_ACK  = 3200;
  localparam int LIMIT     = 8 * FRAME_LEN + 2 * SLOW_ACK + 3 * 1024 + 5000;

  logic clk = 1'b0;
  logic reset, eth_broadcast, eth_valid, eth_unreachable, watchdog_up, cmd_ack;
  logic [15:0] eth_port;
  logic [7:0]  eth_data;
  logic run, wide_spectrum, discovery, cmd_req, cmd_overrun;
  logic lr_valid, iq_valid, subframe_last;
  ds_pkg::ds_cmd_t    cmd;
  ds_pkg::ds_sample_t sample;

  logic [7:0]  frame[$];
  logic [39:0] exp_cmd[$];
  logic [32:0] exp_lr[$];
  logic [32:0] exp_iq[$];
  logic [39:0] first_cmd, last_cmd;
  string test_name;
  int    tests, checks, errors, test_errors, disc_count, off;
  int    ack_delay = FAST_ACK;
  logic  req_seen = 1'b0;

  ds_unpacker_top u_dut (.*);

  always #2 clk = ~clk;

  task automatic report_error(input string what);
    $display("error in %s: %s", test_name, what);
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [39:0] expected,
                             input logic [39:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // Expected commands and sample words for the first n bytes of the frame at off
  function automatic void predict_frame(input int off, input int n);
    ds_pkg::ds_cmd_t c;
    int base;
    int pos;
    for (int sf = 0; sf < 2; sf++) begin
      base = off + 8 + sf * (8 + 8 * `DS_SAMPLES);
      if (base + 8 <= off + n) begin
        c.resprqst = frame[base+3][7];
        c.addr     = frame[base+3][6:1];
        c.ptt      = frame[base+3][0];
        c.data     = {frame[base+4], frame[base+5], frame[base+6], frame[base+7]};
        exp_cmd.push_back(c);
      end
      for (int g = 0; g < `DS_SAMPLES; g++) begin
        pos = base + 8 + 8 * g;
        if (pos + 4 <= off + n)
          exp_lr.push_back({g == `DS_SAMPLES - 1, frame[pos], frame[pos+1],
                            frame[pos+2], frame[pos+3]});
        if (pos + 8 <= off + n)
          exp_iq.push_back({g == `DS_SAMPLES - 1, frame[pos+4], frame[pos+5],
                            frame[pos+6], frame[pos+7]});
      end
    end
  endfunction

  task automatic build_data_frame();
    frame.push_back(`DS_PRE0);
    frame.push_back(`DS_PRE1);
    frame.push_back(`DS_TYPE_DATA);
    frame.push_back(`DS_ENDPOINT_TX);
    repeat (4) frame.push_back(8'($urandom));
    for (int sf = 0; sf < 2; sf++) begin
      repeat (3) frame.push_back(`DS_SYNC);
      // Control byte, four command bytes, then the sample groups
      repeat (5 + 8 * `DS_SAMPLES) frame.push_back(8'($urandom));
    end
  endtask

  task automatic send_frame(input int n, input logic [15:0] port, input logic bcast);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      eth_port      <= port;
      eth_broadcast <= bcast;
      eth_valid     <= 1'b1;
      eth_data      <= frame[i];
    end
    @(posedge clk);
    eth_valid <= 1'b0;
  endtask

  task automatic short_packet(input logic [7:0] pre0, input logic [7:0] kind,
                              input logic [7:0] payload, input logic [15:0] port,
                              input logic bcast);
    frame = '{pre0, `DS_PRE1, kind, payload};
    send_frame(4, port, bcast);
    @(posedge clk);
  endtask

  // A cut of 0 sends the whole frame
  task automatic data_frame(input int cut);
    frame.delete();
    build_data_frame();
    predict_frame(0, cut == 0 ? FRAME_LEN : cut);
    send_frame(cut == 0 ? FRAME_LEN : cut, `DS_PORT, 1'b0);
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while ((exp_cmd.size() + exp_lr.size() + exp_iq.size() != 0 || cmd_req || cmd_ack)
           && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    assert (n < max_cycles) else report_error("expected outputs did not arrive in time");
  endtask

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      watchdog_up <= 1'b1;
    end
    @(posedge clk);
    watchdog_up <= 1'b0;
    @(posedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %-10s %0d errors", test_name, test_errors);
    errors += test_errors;
    tests++;
  endtask

  // Compares every DUT output word against the reference queues
  always @(posedge clk) begin
    if (!reset) begin
      if (discovery) disc_count++;
      if (lr_valid) begin
        assert (exp_lr.size() > 0) else report_error("unexpected left/right word");
        if (exp_lr.size() > 0) check_value("lr", exp_lr.pop_front(), {subframe_last, sample});
      end
      if (iq_valid) begin
        assert (exp_iq.size() > 0) else report_error("unexpected I/Q word");
        if (exp_iq.size() > 0) check_value("iq", exp_iq.pop_front(), {subframe_last, sample});
      end
      if (cmd_req && !req_seen) begin
        assert (exp_cmd.size() > 0) else report_error("unexpected command");
        if (exp_cmd.size() > 0) check_value("cmd", exp_cmd.pop_front(), cmd);
      end
    end
    req_seen = cmd_req;
  end

  // Four-phase consumer
  always @(posedge clk) begin
    if (cmd_req && !cmd_ack) begin
      repeat (ack_delay) @(posedge clk);
      cmd_ack <= 1'b1;
      while (cmd_req) @(posedge clk);
      cmd_ack <= 1'b0;
    end
  end

  initial begin
    repeat (LIMIT) @(posedge clk);
    $display("timeout after %0d cycles, tests did not finish", LIMIT);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(36));
    reset = 1'b1;
    eth_port = 16'd0;
    eth_broadcast = 1'b0;
    eth_valid = 1'b0;
    eth_data = 8'd0;
    eth_unreachable = 1'b0;
    watchdog_up = 1'b0;
    cmd_ack = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    begin_test("run_stop");
    short_packet(`DS_PRE0, `DS_TYPE_RUN, 8'h03, `DS_PORT, 1'b0);
    check_value("run", 1, run);
    check_value("wide", 1, wide_spectrum);
    short_packet(`DS_PRE0, `DS_TYPE_RUN, 8'h01, `DS_PORT, 1'b0);
    check_value("wide", 0, wide_spectrum);
    short_packet(`DS_PRE0, `DS_TYPE_RUN, 8'h02, 16'd1025, 1'b0);
    short_packet(8'hee, `DS_TYPE_RUN, 8'h02, `DS_PORT, 1'b0);
    check_value("run", 1, run);
    check_value("wide", 0, wide_spectrum);
    end_test();

    begin_test("discovery");
    disc_count = 0;
    short_packet(`DS_PRE0, `DS_TYPE_DISC, 8'h00, `DS_PORT, 1'b0);
    check_value("pulses", 0, disc_count);
    short_packet(`DS_PRE0, `DS_TYPE_DISC, 8'h00, `DS_PORT, 1'b1);
    check_value("pulses", 1, disc_count);
    end_test();

    begin_test("commands");
    data_frame(0);
    drain(FRAME_LEN);
    check_value("overrun", 0, cmd_overrun);
    end_test();

    begin_test("samples");
    data_frame(0);
    // Cut inside the I/Q half of group 20
    data_frame(16 + 8 * 20 + 6);
    data_frame(0);
    drain(FRAME_LEN);
    end_test();

    begin_test("watchdog");
    tick(1024);
    check_value("run", 0, run);
    short_packet(`DS_PRE0, `DS_TYPE_RUN, 8'h01, `DS_PORT, 1'b0);
    tick(600);
    data_frame(0);
    tick(600);
    check_value("run", 1, run);
    @(posedge clk);
    eth_unreachable <= 1'b1;
    @(posedge clk);
    eth_unreachable <= 1'b0;
    @(posedge clk);
    check_value("run", 0, run);
    drain(FRAME_LEN);
    end_test();

    begin_test("overrun");
    ack_delay = SLOW_ACK;
    frame.delete();
    for (int k = 0; k < 3; k++) begin
      off = frame.size();
      build_data_frame();
      predict_frame(off, FRAME_LEN);
    end
    // Only the first command and the final waiting one survive
    first_cmd = exp_cmd.pop_front();
    last_cmd = exp_cmd.pop_back();
    exp_cmd.delete();
    exp_cmd.push_back(first_cmd);
    exp_cmd.push_back(last_cmd);
    send_frame(3 * FRAME_LEN, `DS_PORT, 1'b0);
    drain(2 * SLOW_ACK + FRAME_LEN);
    check_value("overrun", 1, cmd_overrun);
    ack_delay = FAST_ACK;
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+src
src/ds_pkg.sv
src/ds_frame_parser.sv
src/ds_watchdog.sv
src/ds_cmd_queue.sv
src/ds_sample_packer.sv
src/ds_unpacker_top.sv
testbench/tb_ds_unpacker.sv
